// ==== files.f ====
hw/chan_acq_pkg.sv
hw/acq_stream_if.sv
hw/acq_cfg_if.sv
hw/acq_config_regs.sv
hw/fill_sequencer.sv
hw/sample_packer.sv
hw/fill_assembler.sv
hw/fill_buffer.sv
hw/channel_acq_top.sv
verification/tb_channel_acq.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_channel_acq -f files.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_channel_acq.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_channel_acq;
	import chan_acq_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int NUM_ROWS    = 7;
	localparam int CR_PROMPT   = 0;     // credit back right after each word
	localparam int CR_RELEASE  = 1;     // held until the fill is in, then returned
	localparam int CR_WITHHELD = 2;     // never returned, buffer runs over
	localparam logic [TAG_W-1:0]      CH_TAG   = 16'h5C3A;
	localparam logic [FILL_NUM_W-1:0] INIT_NUM = 24'h00ABCD;

	////////////////////
	// stimulus table, one fill per row
	string      row_name    [NUM_ROWS] = '{"muon_prompt", "laser_prompt", "ped_header_only",
		"disabled_trig", "laser_release", "ped_overflow", "muon_after_reset"};
	fill_type_e row_type    [NUM_ROWS] = '{MUON, LASER, PEDESTAL, DISABLED, LASER, PEDESTAL, MUON};
	int         row_bursts  [NUM_ROWS] = '{3, 5, 0, 0, 20, 40, 2};
	int         row_credit  [NUM_ROWS] = '{CR_PROMPT, CR_PROMPT, CR_PROMPT, CR_PROMPT,
		CR_RELEASE, CR_WITHHELD, CR_PROMPT};
	logic       row_ovr     [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

	logic                  adc_clk;
	logic                  rst_n;
	logic [SAMPLE_W-1:0]   adc_data;
	logic                  adc_ovr;
	logic                  acq_trig;
	logic                  acq_reset;
	logic [1:0]            acq_enable;
	logic                  reg_wr_en;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic [31:0]           reg_wr_data;
	logic                  out_credit = 1'b0;   // driven by the reader model
	logic [WORD_W-1:0]     out_word;
	logic                  out_valid;
	logic                  acq_done;
	logic                  acq_enabled;
	logic                  fill_overflow;

	logic [15:0]           lfsr = 16'd3512;
	logic [LANE_W-1:0]     drv_lane;        // lane value of the sample just driven
	logic [WORD_W-1:0]     exp_q [$];       // reference words in output order
	logic [WORD_W-1:0]     exp_w;
	logic [FILL_NUM_W-1:0] exp_fill_num;
	string                 cur_name = "reset";
	int                    edge_cnt = 0;    // rising edges so far
	int                    done_due = 0;    // edge where acq_done is sampled, 0 when none
	int                    err_cnt = 0;
	int                    rx_cnt = 0;      // words seen on out_valid
	int                    owed = 0;        // credits the reader still holds
	logic                  credit_on = 1'b1;

	channel_acq_top channel_acq_top_i (
		.adc_clk(adc_clk), .rst_n(rst_n), .adc_data(adc_data), .adc_ovr(adc_ovr),
		.acq_trig(acq_trig), .acq_reset(acq_reset), .acq_enable(acq_enable),
		.reg_wr_en(reg_wr_en), .reg_addr(reg_addr), .reg_wr_data(reg_wr_data),
		.out_credit(out_credit), .out_word(out_word), .out_valid(out_valid),
		.acq_done(acq_done), .acq_enabled(acq_enabled), .fill_overflow(fill_overflow)
	);

	initial begin
		adc_clk = 1'b0;
		forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
	end

	always @(posedge adc_clk)
		edge_cnt <= edge_cnt + 1;

	// galois form, taps for a maximal 16-bit sequence
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// header layout from the top bit down, zeros below the fill type
	function automatic logic [WORD_W-1:0] make_header(input logic [23:0] num,
			input logic [15:0] tag, input logic [20:0] bursts, input logic [1:0] ftype);
		make_header          = '0;
		make_header[127:120] = HEADER_MARK;
		make_header[119:96]  = num;
		make_header[95:80]   = tag;
		make_header[79:59]   = bursts;
		make_header[58:57]   = ftype;
	endfunction

	function automatic logic [REG_ADDR_W-1:0] burst_reg(input fill_type_e ft);
		case (ft)
			MUON:    burst_reg = MUON_BURSTS;
			LASER:   burst_reg = LASER_BURSTS;
			default: burst_reg = PED_BURSTS;
		endcase
	endfunction

	// one clock, new sample on the falling edge
	task automatic step();
		int b;
		@(negedge adc_clk);
		for (b = 0; b < SAMPLE_W + 1; b++) begin
			drv_lane[b] = lfsr[0];        // 12 sample bits, then ovr
			lfsr = lfsr_next(lfsr);
		end
		drv_lane[15:13] = 3'b000;
		adc_data = drv_lane[SAMPLE_W-1:0];
		adc_ovr  = drv_lane[SAMPLE_W];
	endtask

	task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
		step();
		reg_wr_en   = 1'b1;
		reg_addr    = addr;
		reg_wr_data = data;
		step();
		reg_wr_en   = 1'b0;
	endtask

	task automatic run_row(input int r);
		int               i;
		int               n;
		int               cnt;
		int               rx_start;
		logic [WORD_W-1:0] word;
		fill_type_e       ft;
		ft       = row_type[r];
		n        = row_bursts[r];
		cur_name = row_name[r];
		word     = '0;
		if (ft != DISABLED)
			write_reg(burst_reg(ft), n);
		step();
		acq_enable = ft;
		credit_on  = (row_credit[r] == CR_PROMPT);
		step();
		acq_trig = 1'b1;                                        // sampled at edge T
		rx_start = rx_cnt;
		if (ft != DISABLED) begin
			exp_q.push_back(make_header(exp_fill_num, CH_TAG, n[20:0], ft));
			done_due = edge_cnt + 1 + 8 * n + 10;
		end
		// sample 0 is driven right after T, retrigger at sample 3
		for (i = 0; i < 8 * n + 8; i++) begin
			step();
			acq_trig = (i == 3);
			assert (acq_enabled == (ft != DISABLED)) else begin
				err_cnt++;
				$display("mismatch %s expected %b actual %b", cur_name, ft != DISABLED,
					acq_enabled);
			end
			if (i < 8 * n) begin
				word[(i % 8) * LANE_W +: LANE_W] = drv_lane;
				if (i % 8 == 7)
					exp_q.push_back(word);
			end
		end
		if (ft == DISABLED) begin
			repeat (12) step();                                 // monitor flags any output
		end else begin
			cnt = 0;
			while (!acq_done && cnt < 20) begin
				step();
				cnt++;
			end
			assert (acq_done) else begin
				err_cnt++;
				$display("%s: acq_done never came", cur_name);
			end
			assert (!acq_enabled) else begin
				err_cnt++;
				$display("%s: acq_enabled still high after acq_done", cur_name);
			end
			exp_fill_num++;
		end
		if (row_credit[r] != CR_PROMPT) begin
			repeat (20) step();                                 // output must stay stalled
			assert (rx_cnt - rx_start == BUF_DEPTH) else begin
				err_cnt++;
				$display("mismatch %s expected %0d actual %0d", cur_name, BUF_DEPTH,
					rx_cnt - rx_start);
			end
		end
		if (row_credit[r] == CR_WITHHELD) begin
			assert (fill_overflow == row_ovr[r]) else begin
				err_cnt++;
				$display("mismatch %s expected %b actual %b", cur_name, row_ovr[r], fill_overflow);
			end
			step();
			acq_reset = 1'b1;
			exp_q.delete();                                     // buffer is flushed
			owed = 0;                                           // credits back to full
			step();
			acq_reset = 1'b0;
			step();
			assert (fill_overflow == 1'b0) else begin
				err_cnt++;
				$display("%s: fill_overflow still high after acq_reset", cur_name);
			end
			credit_on = 1'b1;
		end else begin
			credit_on = 1'b1;
			cnt = 0;
			// words still queued and credits still held by the reader
			while ((exp_q.size() != 0 || owed != 0) && cnt < 60) begin
				step();
				cnt++;
			end
			assert (exp_q.size() == 0) else begin
				err_cnt++;
				$display("%s: %0d words never came out", cur_name, exp_q.size());
			end
			repeat (4) step();                                  // last credits go home
			assert (fill_overflow == row_ovr[r]) else begin
				err_cnt++;
				$display("mismatch %s expected %b actual %b", cur_name, row_ovr[r], fill_overflow);
			end
		end
	endtask

	////////////////////
	// reader model and output checks
	always @(negedge adc_clk) begin
		if (rst_n) begin
			if (out_valid) begin
				rx_cnt++;
				owed++;
				assert (exp_q.size() != 0) else begin
					err_cnt++;
					$display("%s: word came out with none expected", cur_name);
				end
				if (exp_q.size() != 0) begin
					exp_w = exp_q.pop_front();
					assert (out_word == exp_w) else begin
						err_cnt++;
						$display("mismatch %s expected %h actual %h", cur_name, exp_w, out_word);
					end
				end
			end
			if (acq_done) begin
				assert (done_due != 0) else begin
					err_cnt++;
					$display("%s: acq_done pulse with no fill running", cur_name);
				end
				if (done_due != 0) begin
					assert (edge_cnt + 1 == done_due) else begin
						err_cnt++;
						$display("mismatch %s expected %0d actual %0d", cur_name, done_due,
							edge_cnt + 1);
					end
				end
				done_due = 0;                                   // a second pulse is an error
			end
			if (credit_on && owed > 0) begin
				out_credit = 1'b1;
				owed--;
			end else begin
				out_credit = 1'b0;
			end
		end
	end

	////////////////////
	// main sequence
	initial begin
		int r;
		rst_n       = 1'b0;
		adc_data    = '0;
		adc_ovr     = 1'b0;
		acq_trig    = 1'b0;
		acq_reset   = 1'b0;
		acq_enable  = 2'b00;
		reg_wr_en   = 1'b0;
		reg_addr    = '0;
		reg_wr_data = '0;
		repeat (10) step();
		rst_n = 1'b1;
		write_reg(TAG, CH_TAG);
		write_reg(INIT_FILL_NUM, INIT_NUM);
		exp_fill_num = INIT_NUM;
		for (r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("errors: %0d", err_cnt);
		if (err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// run length follows the fill sizes in the table
	initial begin
		int     r;
		longint limit;
		limit = 0;
		for (r = 0; r < NUM_ROWS; r++)
			limit += 8 * row_bursts[r] + 50;
		#(limit * CLK_PERIOD);
		$display("watchdog expired in %s, errors: %0d", cur_name, err_cnt);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/channel_acq_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module channel_acq_top (
	input  wire                                 adc_clk,        // adc sample clock
	input  wire                                 rst_n,
	input  wire [chan_acq_pkg::SAMPLE_W-1:0]    adc_data,
	input  wire                                 adc_ovr,
	input  wire                                 acq_trig,
	input  wire                                 acq_reset,
	input  wire [1:0]                           acq_enable,     // fill type select
	input  wire                                 reg_wr_en,
	input  wire [chan_acq_pkg::REG_ADDR_W-1:0]  reg_addr,
	input  wire [31:0]                          reg_wr_data,
	input  wire                                 out_credit,
	output wire [chan_acq_pkg::WORD_W-1:0]      out_word,
	output wire                                 out_valid,
	output wire                                 acq_done,
	output wire                                 acq_enabled,
	output wire                                 fill_overflow
);
	import chan_acq_pkg::*;

	logic                   pack_run;
	logic                   hdr_load;
	logic                   word_ready;
	fill_type_e             fill_type;
	logic [BURST_CNT_W-1:0] burst_count;
	logic [FILL_NUM_W-1:0]  fill_num;
	logic [WORD_W-1:0]      burst_word;

	acq_cfg_if    cfg_if ();
	acq_stream_if stream_if ();

	acq_config_regs acq_config_regs_i (
		.adc_clk(adc_clk), .rst_n(rst_n), .reg_wr_en(reg_wr_en),
		.reg_addr(reg_addr_e'(reg_addr)), .reg_wr_data(reg_wr_data), .cfg(cfg_if.regs)
	);

	fill_sequencer fill_sequencer_i (
		.adc_clk(adc_clk), .rst_n(rst_n), .acq_trig(acq_trig), .acq_reset(acq_reset),
		.acq_enable(acq_enable), .cfg(cfg_if.seq), .pack_run(pack_run), .hdr_load(hdr_load),
		.fill_type(fill_type), .burst_count(burst_count), .fill_num(fill_num),
		.acq_done(acq_done), .acq_enabled(acq_enabled), .word_ready(word_ready)
	);

	sample_packer sample_packer_i (
		.adc_clk(adc_clk), .rst_n(rst_n), .adc_data(adc_data), .adc_ovr(adc_ovr),
		.pack_run(pack_run), .burst_word(burst_word), .word_ready(word_ready)
	);

	fill_assembler fill_assembler_i (
		.adc_clk(adc_clk), .rst_n(rst_n), .hdr_load(hdr_load), .fill_type(fill_type),
		.burst_count(burst_count), .fill_num(fill_num), .burst_word(burst_word),
		.word_ready(word_ready), .pack_run(pack_run), .cfg(cfg_if.asm), .stream(stream_if.src)
	);

	fill_buffer fill_buffer_i (
		.adc_clk(adc_clk), .rst_n(rst_n), .acq_reset(acq_reset), .out_credit(out_credit),
		.stream(stream_if.sink), .out_word(out_word), .out_valid(out_valid),
		.fill_overflow(fill_overflow)
	);

endmodule

`default_nettype wire

// ==== hw/fill_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module fill_buffer (
	input  wire                              adc_clk,
	input  wire                              rst_n,
	input  wire                              acq_reset,      // flush, refill credits
	input  wire                              out_credit,     // reader returns one slot
	acq_stream_if.sink                       stream,
	output logic [chan_acq_pkg::WORD_W-1:0]  out_word,
	output logic                             out_valid,      // one word, one credit
	output logic                             fill_overflow   // sticky, a word was lost
);
	import chan_acq_pkg::*;

	logic [WORD_W-1:0]    mem [BUF_DEPTH];
	logic [BUF_PTR_W-1:0] wr_ptr;
	logic [BUF_PTR_W-1:0] rd_ptr;
	logic [BUF_CNT_W-1:0] fill_cnt;     // words waiting
	logic [BUF_CNT_W-1:0] credit_cnt;   // words the reader can still take
	logic                 full;
	logic                 empty;
	logic                 push;
	logic                 pop;

	assign full  = (fill_cnt == BUF_CNT_W'(BUF_DEPTH));
	assign empty = (fill_cnt == '0);
	assign push  = stream.valid && !full;                           // full drops the word
	assign pop   = !empty && (credit_cnt != '0);

	////////////////////
	// storage and output register
	always_ff @(posedge adc_clk) begin
		if (push)
			mem[wr_ptr] <= stream.word;
		if (pop)
			out_word <= mem[rd_ptr];
	end

	////////////////////
	// pointers, level and credits
	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			fill_cnt      <= '0;
			credit_cnt    <= BUF_CNT_W'(BUF_DEPTH);
			out_valid     <= 1'b0;
			fill_overflow <= 1'b0;
		end else if (acq_reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			fill_cnt      <= '0;
			credit_cnt    <= BUF_CNT_W'(BUF_DEPTH);
			out_valid     <= 1'b0;
			fill_overflow <= 1'b0;
		end else begin
			out_valid <= pop;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			fill_cnt   <= fill_cnt + BUF_CNT_W'(push) - BUF_CNT_W'(pop);
			credit_cnt <= credit_cnt + BUF_CNT_W'(out_credit) - BUF_CNT_W'(pop);
			if (stream.valid && full)
				fill_overflow <= 1'b1;
		end
	end

	// reader never hands back more credits than slots
	a_credit_max: assert property (@(posedge adc_clk) disable iff (!rst_n)
		credit_cnt <= BUF_CNT_W'(BUF_DEPTH));

	a_credit_out: assert property (@(posedge adc_clk) disable iff (!rst_n)
		out_valid |-> $past(credit_cnt) != '0);

	// nothing but a new header may follow the last word of a fill
	a_fill_frame: assert property (@(posedge adc_clk) disable iff (!rst_n)
		stream.valid && stream.last |=> !stream.valid || stream.first);

endmodule

`default_nettype wire

// ==== hw/fill_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none

module fill_assembler (
	input  wire                                  adc_clk,
	input  wire                                  rst_n,
	input  wire                                  hdr_load,      // trigger edge
	input  var  chan_acq_pkg::fill_type_e        fill_type,
	input  wire [chan_acq_pkg::BURST_CNT_W-1:0]  burst_count,
	input  wire [chan_acq_pkg::FILL_NUM_W-1:0]   fill_num,
	input  wire [chan_acq_pkg::WORD_W-1:0]       burst_word,
	input  wire                                  word_ready,
	input  wire                                  pack_run,      // fill still running
	acq_cfg_if.asm                               cfg,
	acq_stream_if.src                            stream
);
	import chan_acq_pkg::*;

	logic [WORD_W-1:0]      header;
	logic [BURST_CNT_W-1:0] bursts_lat;    // count taken with the header
	logic [BURST_CNT_W-1:0] bursts_sent;
	logic                   fwd;           // pass this burst word on

	assign header = {HEADER_MARK, fill_num, cfg.channel_tag, burst_count, fill_type,
	                 {HDR_PAD_W{1'b0}}};

	// the packer runs one spare word at the end of a fill, keep it off the stream
	assign fwd = pack_run && word_ready && (bursts_sent != bursts_lat);

	always_ff @(posedge adc_clk) begin
		if (hdr_load)
			stream.word <= header;
		else if (fwd)
			stream.word <= burst_word;
	end

	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			stream.valid <= 1'b0;
			stream.first <= 1'b0;
			stream.last  <= 1'b0;
			bursts_lat   <= '0;
			bursts_sent  <= '0;
		end else begin
			stream.valid <= hdr_load || fwd;
			stream.first <= hdr_load;
			if (hdr_load) begin
				stream.last <= (burst_count == '0);                     // header-only fill
				bursts_lat  <= burst_count;
				bursts_sent <= '0;
			end else if (fwd) begin
				stream.last <= (bursts_sent == bursts_lat - 1'b1);
				bursts_sent <= bursts_sent + 1'b1;
			end else begin
				stream.last <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/sample_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

module sample_packer (
	input  wire                               adc_clk,
	input  wire                               rst_n,
	input  wire [chan_acq_pkg::SAMPLE_W-1:0]  adc_data,     // new sample every clock
	input  wire                               adc_ovr,      // over-range for adc_data
	input  wire                               pack_run,     // sequencer wants samples
	output logic [chan_acq_pkg::WORD_W-1:0]   burst_word,   // valid with word_ready
	output logic                              word_ready
);
	import chan_acq_pkg::*;

	logic [LANE_W-1:0]                        cur_lane;   // sample on the pins now
	logic [(SAMPLES_PER_WORD-1)*LANE_W-1:0]   lanes_q;    // lanes 0 to 6
	logic [LANE_CNT_W-1:0]                    lane_cnt;   // samples held so far

	assign cur_lane = {{LANE_PAD_W{1'b0}}, adc_ovr, adc_data};

	// eighth sample joins straight from the pins so the word is ready at its edge
	assign word_ready = pack_run && (lane_cnt == LANE_CNT_W'(SAMPLES_PER_WORD - 1));
	assign burst_word = {cur_lane, lanes_q};

	// new sample enters at the top lane, older ones move down toward lane 0
	always_ff @(posedge adc_clk) begin
		if (pack_run)
			lanes_q <= {cur_lane, lanes_q[(SAMPLES_PER_WORD-1)*LANE_W-1:LANE_W]};
	end

	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n)
			lane_cnt <= '0;
		else if (!pack_run)
			lane_cnt <= '0;                                         // realign for the next fill
		else
			lane_cnt <= lane_cnt + 1'b1;                            // wraps after lane 7
	end

endmodule

`default_nettype wire

// ==== hw/fill_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module fill_sequencer (
	input  wire                                   adc_clk,
	input  wire                                   rst_n,
	input  wire                                   acq_trig,      // start a fill when idle
	input  wire                                   acq_reset,     // abort back to idle
	input  wire [1:0]                             acq_enable,    // fill type pins
	acq_cfg_if.seq                                cfg,
	output logic                                  pack_run,      // packer takes samples
	output logic                                  hdr_load,      // header goes out this edge
	output chan_acq_pkg::fill_type_e              fill_type,
	output logic [chan_acq_pkg::BURST_CNT_W-1:0]  burst_count,
	output logic [chan_acq_pkg::FILL_NUM_W-1:0]   fill_num,
	output logic                                  acq_done,      // one cycle per fill
	output logic                                  acq_enabled,   // busy with a fill
	input  wire                                   word_ready     // packer has a full word
);
	import chan_acq_pkg::*;

	seq_state_e             state;
	fill_type_e             type_sel;     // live decode of the pins
	fill_type_e             type_lat;     // held for the running fill
	logic [BURST_CNT_W-1:0] count_sel;    // burst count for type_sel
	logic [BURST_CNT_W-1:0] count_lat;
	logic [BURST_CNT_W-1:0] words_left;   // burst words still to come

	assign type_sel = fill_type_e'(acq_enable);                     // bit 1 is the high bit

	always_comb begin
		case (type_sel)
			MUON:     count_sel = cfg.muon_bursts;
			LASER:    count_sel = cfg.laser_bursts;
			PEDESTAL: count_sel = cfg.ped_bursts;
			default:  count_sel = '0;
		endcase
	end

	// trigger edge T
	assign hdr_load    = (state == IDLE) && acq_trig && (type_sel != DISABLED) && !acq_reset;
	assign pack_run    = (state == HEADER) || (state == SAMPLES);
	assign acq_enabled = (state != IDLE);
	assign fill_type   = (state == IDLE) ? type_sel : type_lat;      // asm snapshots at T
	assign burst_count = (state == IDLE) ? count_sel : count_lat;

	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			type_lat   <= DISABLED;
			count_lat  <= '0;
			words_left <= '0;
			fill_num   <= '0;
			acq_done   <= 1'b0;
		end else begin
			acq_done <= 1'b0;
			if (acq_reset) begin
				state <= IDLE;                                          // fill number is kept
			end else begin
				case (state)
					IDLE: if (hdr_load) begin
						state      <= HEADER;
						type_lat   <= type_sel;
						count_lat  <= count_sel;
						words_left <= count_sel;
					end
					HEADER: state <= SAMPLES;                               // sample 0 taken here
					SAMPLES: if (word_ready) begin
						// one word period past the last burst closes the fill
						if (words_left == '0)
							state <= DONE;
						else
							words_left <= words_left - 1'b1;
					end
					DONE: begin
						state    <= IDLE;
						acq_done <= 1'b1;
						fill_num <= fill_num + 1'b1;
					end
					default: state <= IDLE;
				endcase
			end
			if (cfg.init_fill_num_wr)
				fill_num <= cfg.init_fill_num;                          // a register write wins
		end
	end

	a_done_idle: assert property (@(posedge adc_clk) disable iff (!rst_n)
		acq_done |-> !pack_run);

endmodule

`default_nettype wire

// ==== hw/acq_config_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module acq_config_regs (
	input  wire                          adc_clk,       // adc sample clock
	input  wire                          rst_n,         // async, active low
	input  wire                          reg_wr_en,     // one-cycle write strobe
	input  var  chan_acq_pkg::reg_addr_e reg_addr,      // register select
	input  wire [31:0]                   reg_wr_data,   // low bits used per register
	acq_cfg_if.regs                      cfg            // settings out to seq and asm
);
	import chan_acq_pkg::*;

	always_ff @(posedge adc_clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg.channel_tag      <= '0;
			cfg.muon_bursts      <= '0;
			cfg.laser_bursts     <= '0;
			cfg.ped_bursts       <= '0;
			cfg.init_fill_num    <= '0;
			cfg.init_fill_num_wr <= 1'b0;
		end else begin
			cfg.init_fill_num_wr <= 1'b0;                                 // strobe lasts one cycle
			if (reg_wr_en) begin
				case (reg_addr)
					TAG:           cfg.channel_tag  <= reg_wr_data[TAG_W-1:0];
					MUON_BURSTS:   cfg.muon_bursts  <= reg_wr_data[BURST_CNT_W-1:0];
					LASER_BURSTS:  cfg.laser_bursts <= reg_wr_data[BURST_CNT_W-1:0];
					PED_BURSTS:    cfg.ped_bursts   <= reg_wr_data[BURST_CNT_W-1:0];
					INIT_FILL_NUM: begin
						cfg.init_fill_num    <= reg_wr_data[FILL_NUM_W-1:0];
						cfg.init_fill_num_wr <= 1'b1;                         // sequencer reloads next cycle
					end
					default: ;                                                // unmapped, dropped
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/acq_cfg_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface acq_cfg_if;
	import chan_acq_pkg::*;

	logic [TAG_W-1:0]       channel_tag;        // copied into every header
	logic [BURST_CNT_W-1:0] muon_bursts;        // bursts in a MUON fill
	logic [BURST_CNT_W-1:0] laser_bursts;       // bursts in a LASER fill
	logic [BURST_CNT_W-1:0] ped_bursts;         // bursts in a PEDESTAL fill
	logic [FILL_NUM_W-1:0]  init_fill_num;      // start value of the fill number
	logic                   init_fill_num_wr;   // one cycle, follows the write

	modport regs (
		output channel_tag, muon_bursts, laser_bursts, ped_bursts,
		       init_fill_num, init_fill_num_wr
	);

	modport seq (
		input  muon_bursts, laser_bursts, ped_bursts, init_fill_num, init_fill_num_wr
	);

	modport asm (
		input  channel_tag
	);

endinterface

`default_nettype wire

// ==== hw/acq_stream_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// fill words from the assembler into the buffer, no back-pressure
interface acq_stream_if;
	import chan_acq_pkg::*;

	logic [WORD_W-1:0] word;    // header or burst word
	logic              valid;   // word is here for this cycle only
	logic              first;   // marks the header word
	logic              last;    // marks the final word of a fill

	modport src (
		output word, valid, first, last
	);

	modport sink (
		input  word, valid, first, last
	);

endinterface

`default_nettype wire

// ==== hw/chan_acq_pkg.sv ====
`default_nettype none

package chan_acq_pkg;

	////////////////////
	// sample and word geometry
	localparam int SAMPLE_W         = 12;                        // adc sample bits
	localparam int LANE_W           = 16;                        // one sample lane in a burst word
	localparam int SAMPLES_PER_WORD = 8;                         // lanes per burst word
	localparam int WORD_W           = 128;                       // fill word width
	localparam int LANE_PAD_W       = LANE_W - SAMPLE_W - 1;     // zero bits above the ovr flag
	localparam int LANE_CNT_W       = $clog2(SAMPLES_PER_WORD);  // lane counter in the packer

	////////////////////
	// header fields
	localparam int BURST_CNT_W      = 21;                        // bursts per fill
	localparam int FILL_NUM_W       = 24;                        // running fill number
	localparam int TAG_W            = 16;                        // channel tag
	localparam logic [7:0] HEADER_MARK = 8'hA5;                  // top byte of every header
	localparam int HDR_PAD_W = WORD_W - 8 - FILL_NUM_W - TAG_W - BURST_CNT_W - 2;

	////////////////////
	// fill buffer and register port
	localparam int BUF_DEPTH        = 16;                        // slots, also the initial credits
	localparam int BUF_PTR_W        = $clog2(BUF_DEPTH);
	localparam int BUF_CNT_W        = BUF_PTR_W + 1;             // holds 0 to BUF_DEPTH
	localparam int REG_ADDR_W       = 3;

	typedef enum logic [1:0] {
		DISABLED = 2'd0,   // no triggers taken
		MUON     = 2'd1,
		LASER    = 2'd2,
		PEDESTAL = 2'd3
	} fill_type_e;

	typedef enum logic [1:0] {IDLE, HEADER, SAMPLES, DONE} seq_state_e;

	typedef enum logic [REG_ADDR_W-1:0] {
		TAG           = 3'd0,
		MUON_BURSTS   = 3'd1,
		LASER_BURSTS  = 3'd2,
		PED_BURSTS    = 3'd3,
		INIT_FILL_NUM = 3'd4
	} reg_addr_e;

endpackage

`default_nettype wire
